// ==== Bender.yml ====
package:
  name: pipe

sources:
  - src/pipe_pkg.sv
  - src/fetch_stage.sv
  - src/decode_stage.sv
  - src/ex1_stage.sv
  - src/ex2_stage.sv
  - src/pipe_top.sv
  - target: test
    files:
      - tests/pipe_tb.sv

// ==== all.f ====
src/pipe_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/ex1_stage.sv
src/ex2_stage.sv
src/pipe_top.sv
tests/pipe_tb.sv

// ==== src/decode_stage.sv ====
// Instruction decode stage
// Splits the IF/ID word into opcode, destination and source, reads the
// source from the register file with a bypass of the value being written
// back, compares the source with the destinations further down the pipe,
// raises the load-use stall and loads the ID/EX1 register
`timescale 1ns/1ps

module decode_stage (
	input  logic                CLK,
	input  logic                RSTB,
	input  pipe_pkg::instr_t    id_instr,
	input  pipe_pkg::reg_addr_t ex2_ra,
	input  logic                wb_write,
	input  pipe_pkg::reg_addr_t wb_ra,
	input  pipe_pkg::data_t     wb_rd,
	output logic                stall,
	output pipe_pkg::op_e       ex1_op,
	output pipe_pkg::reg_addr_t ex1_ra,
	output pipe_pkg::data_t     ex1_xd,
	output logic                ex1_xmex1,
	output logic                ex1_xmex2
);

	import pipe_pkg::*;

	// Decoded fields of the instruction in ID
	op_e       id_op;
	reg_addr_t id_ra;
	reg_addr_t id_xa;

	// Source operand after the WB bypass
	data_t id_xd;

	// Outputs of the compare station
	logic id_xmex1;
	logic id_xmex2;

	// 16 x 16 register file
	data_t regs [NUM_REGS];

	// --------------------------------------------------------------------------
	// Field decode
	// --------------------------------------------------------------------------

	assign id_op = op_e'(id_instr[OP_LSB +: $bits(op_e)]);
	assign id_ra = id_instr[RA_LSB +: REG_AW];
	assign id_xa = id_instr[XA_LSB +: REG_AW];

	// --------------------------------------------------------------------------
	// Register file
	// --------------------------------------------------------------------------

	// Every register starts at zero and takes the write-back data when wb_write is high
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wb_write)
		begin
			regs[wb_ra] <= wb_rd;
		end
	end

	// The write lands on the same edge that ID/EX1 captures the read,
	// so a matching write-back is routed around the array
	assign id_xd = (wb_write && (wb_ra == id_xa)) ? wb_rd : regs[id_xa];

	// --------------------------------------------------------------------------
	// Hazard detection
	// --------------------------------------------------------------------------

	// Source against the destinations one and two instructions ahead
	assign id_xmex1 = (id_xa == ex1_ra);
	assign id_xmex2 = (id_xa == ex2_ra);

	// SUB3 and ADD1 need their operand at the start of EX1, but an ADD4 or
	// ADD1 one slot ahead only has its sum at the end of EX2
	// One bubble closes that gap
	assign stall = id_xmex1
		&& ((id_op == OP_SUB3) || (id_op == OP_ADD1))
		&& ((ex1_op == OP_ADD4) || (ex1_op == OP_ADD1));

	// --------------------------------------------------------------------------
	// ID/EX1 register
	// --------------------------------------------------------------------------

	// On a stall the opcode becomes a NOP and the instruction stays in ID
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			ex1_op    <= OP_NOP;
			ex1_xmex1 <= 1'b0;
			ex1_xmex2 <= 1'b0;
		end
		else
		begin
			ex1_op    <= stall ? OP_NOP : id_op;
			ex1_xmex1 <= id_xmex1;
			ex1_xmex2 <= id_xmex2;
		end
	end

	// Operand and destination of the instruction leaving ID
	always_ff @(posedge CLK)
	begin
		ex1_ra <= id_ra;
		ex1_xd <= id_xd;
	end

endmodule

// ==== src/ex1_stage.sv ====
// First execute stage
// Picks the operand from the register read, from EX2 or from WB, runs the
// subtract-3 unit for SUB3 and ADD1, and passes the operand unchanged for
// the other opcodes into the EX1/EX2 register
`timescale 1ns/1ps

module ex1_stage (
	input  logic                CLK,
	input  logic                RSTB,
	input  pipe_pkg::op_e       ex1_op,
	input  pipe_pkg::reg_addr_t ex1_ra,
	input  pipe_pkg::data_t     ex1_xd,
	input  logic                ex1_xmex1,
	input  logic                ex1_xmex2,
	input  pipe_pkg::data_t     ex2_fwd,
	input  logic                wb_write,
	input  pipe_pkg::data_t     wb_rd,
	output pipe_pkg::op_e       ex2_op,
	output pipe_pkg::reg_addr_t ex2_ra,
	output pipe_pkg::data_t     ex2_xd,
	output logic                ex2_xmex1
);

	import pipe_pkg::*;

	logic  prio;
	logic  forw1;
	logic  skip1;
	data_t prio_xd;
	data_t sub_in;
	data_t sub_out;

	// --------------------------------------------------------------------------
	// Operand forwarding
	// --------------------------------------------------------------------------

	// SUB3 and MOV in EX2 already hold their final value, and it is newer
	// than anything in WB, so that path wins
	assign prio = ex1_xmex1 && ((ex2_op == OP_SUB3) || (ex2_op == OP_MOV));

	// Otherwise an instruction two slots ahead helps from WB
	assign forw1 = prio || (ex1_xmex2 && wb_write);

	// ex2_fwd is the EX2 operand after its own WB forwarding, which covers a
	// MOV in EX2 that itself depends on WB
	assign prio_xd = prio ? ex2_fwd : wb_rd;
	assign sub_in  = forw1 ? prio_xd : ex1_xd;

	// --------------------------------------------------------------------------
	// Subtract unit and skip mux
	// --------------------------------------------------------------------------

	assign sub_out = sub_in - SUB_CONST;

	// Only SUB3 and ADD1 use the subtractor
	assign skip1 = !((ex1_op == OP_SUB3) || (ex1_op == OP_ADD1));

	// --------------------------------------------------------------------------
	// EX1/EX2 register
	// --------------------------------------------------------------------------

	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			ex2_op    <= OP_NOP;
			ex2_xmex1 <= 1'b0;
		end
		else
		begin
			ex2_op    <= ex1_op;
			ex2_xmex1 <= ex1_xmex1;
		end
	end

	// The data path takes the result of the skip mux
	always_ff @(posedge CLK)
	begin
		ex2_ra <= ex1_ra;
		ex2_xd <= skip1 ? sub_in : sub_out;
	end

endmodule

// ==== src/ex2_stage.sv ====
// Second execute stage and write-back
// Forwards the write-back value into the EX2 operand for ADD4 and MOV,
// runs the add-4 unit and registers both operand and sum. The WB mux then
// picks one of them to form the write-back data for the register file
`timescale 1ns/1ps

module ex2_stage (
	input  logic                CLK,
	input  logic                RSTB,
	input  pipe_pkg::op_e       ex2_op,
	input  pipe_pkg::reg_addr_t ex2_ra,
	input  pipe_pkg::data_t     ex2_xd,
	input  logic                ex2_xmex1,
	output pipe_pkg::data_t     ex2_fwd,
	output logic                wb_write,
	output pipe_pkg::reg_addr_t wb_ra,
	output pipe_pkg::data_t     wb_rd
);

	import pipe_pkg::*;

	logic  forw2;
	logic  skip2;
	data_t add_out;

	// WB stage registers that feed the result mux
	logic  wb_skip;
	data_t wb_opnd;
	data_t wb_sum;

	// --------------------------------------------------------------------------
	// Operand forwarding and add unit
	// --------------------------------------------------------------------------

	// SUB3 and ADD1 got their operand in EX1, so only ADD4 and MOV pick up
	// a result from the instruction just ahead, now in WB
	assign forw2 = ex2_xmex1 && ((ex2_op == OP_ADD4) || (ex2_op == OP_MOV)) && wb_write;

	// This is also the value that EX1 takes on its priority path
	assign ex2_fwd = forw2 ? wb_rd : ex2_xd;

	assign add_out = ex2_fwd + ADD_CONST;

	// ADD4 and ADD1 keep the sum, everything else the operand
	assign skip2 = !((ex2_op == OP_ADD4) || (ex2_op == OP_ADD1));

	// --------------------------------------------------------------------------
	// EX2/WB register
	// --------------------------------------------------------------------------

	// Any nonzero opcode writes back, a NOP or a bubble does not
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			wb_write <= 1'b0;
			wb_skip  <= 1'b1;
		end
		else
		begin
			wb_write <= (ex2_op != OP_NOP);
			wb_skip  <= skip2;
		end
	end

	always_ff @(posedge CLK)
	begin
		wb_ra   <= ex2_ra;
		wb_opnd <= ex2_fwd;
		wb_sum  <= add_out;
	end

	// --------------------------------------------------------------------------
	// WB result mux
	// --------------------------------------------------------------------------

	// Placed after the register so the sum path has a full cycle of its own
	assign wb_rd = wb_skip ? wb_opnd : wb_sum;

endmodule

// ==== src/fetch_stage.sv ====
// Instruction fetch stage
// Holds the program counter and the 64-word instruction memory, which is
// loaded through a write port while the pipeline sits in reset. The fetched
// word is captured in the IF/ID register, and both the PC and the IF/ID
// register freeze while decode asks for a stall
`timescale 1ns/1ps

module fetch_stage (
	input  logic                 CLK,
	input  logic                 RSTB,
	input  logic                 stall,
	input  logic                 imem_we,
	input  pipe_pkg::imem_addr_t imem_addr,
	input  pipe_pkg::instr_t     imem_wdata,
	output pipe_pkg::instr_t     id_instr
);

	import pipe_pkg::*;

	// Instruction storage filled through the load port
	instr_t imem [IMEM_DEPTH];

	// Program counter and the memory address taken from it
	logic [PC_W-1:0] pc;
	imem_addr_t      fetch_addr;
	instr_t          if_instr;

	// --------------------------------------------------------------------------
	// Memory load port
	// --------------------------------------------------------------------------

	// Writes are synchronous and are expected only while RSTB is low
	always_ff @(posedge CLK)
	begin
		if (imem_we)
		begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	// --------------------------------------------------------------------------
	// Fetch and IF/ID register
	// --------------------------------------------------------------------------

	// The upper PC bits are ignored, so the program wraps every 64 words
	assign fetch_addr = pc[IMEM_AW-1:0];

	// Asynchronous read of the current word
	assign if_instr = imem[fetch_addr];

	// A zero word in IF/ID decodes as a NOP, which is what ID sees after reset
	always_ff @(posedge CLK or negedge RSTB)
	begin
		if (!RSTB)
		begin
			pc       <= '0;
			id_instr <= '0;
		end
		else if (!stall)
		begin
			// During a stall the same word is fetched again next cycle
			pc       <= pc + 1'b1;
			id_instr <= if_instr;
		end
	end

endmodule

// ==== src/pipe_pkg.sv ====
// Shared definitions for the five-stage pipelined datapath
// Holds the data and address widths, the instruction field positions, the
// constants of the two adders and the one-hot opcode encoding that every
// stage decodes
package pipe_pkg;

	// --------------------------------------------------------------------------
	// Sizes of the register file, the instruction memory and the program counter
	// --------------------------------------------------------------------------
	localparam int DATA_W     = 16;
	localparam int REG_AW     = 4;
	localparam int NUM_REGS   = 16;
	localparam int INSTR_W    = 32;
	localparam int IMEM_AW    = 6;
	localparam int IMEM_DEPTH = 64;
	// The PC is wider than the memory address and only its low bits are used
	localparam int PC_W       = 8;

	// The opcode sits in [31:28], the destination in [7:4] and the source in [3:0]
	localparam int OP_LSB = 28;
	localparam int RA_LSB = 4;
	localparam int XA_LSB = 0;

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [REG_AW-1:0]  reg_addr_t;
	typedef logic [INSTR_W-1:0] instr_t;
	typedef logic [IMEM_AW-1:0] imem_addr_t;

	// EX1 subtracts this amount and EX2 adds the other one
	localparam data_t SUB_CONST = data_t'(3);
	localparam data_t ADD_CONST = data_t'(4);

	// One-hot opcode where ADD1 runs through both units, first minus 3 and then plus 4
	typedef enum logic [3:0] {
		OP_NOP  = 4'b0000,
		OP_ADD1 = 4'b0001,
		OP_ADD4 = 4'b0010,
		OP_SUB3 = 4'b0100,
		OP_MOV  = 4'b1000
	} op_e;

endpackage

// ==== src/pipe_top.sv ====
// Top level of the five-stage pipelined datapath
// Chains fetch, decode, the two execute stages and write-back. The
// instruction memory load port and the write-back stream are brought out
// so a testbench can load a program and watch every register write
`timescale 1ns/1ps

module pipe_top (
	input  logic                 CLK,
	input  logic                 RSTB,
	input  logic                 imem_we,
	input  pipe_pkg::imem_addr_t imem_addr,
	input  pipe_pkg::instr_t     imem_wdata,
	output logic                 wb_write,
	output pipe_pkg::reg_addr_t  wb_ra,
	output pipe_pkg::data_t      wb_rd
);

	import pipe_pkg::*;

	// IF/ID and the stall fed back from decode
	instr_t    id_instr;
	logic      stall;

	// ID/EX1 register
	op_e       ex1_op;
	reg_addr_t ex1_ra;
	data_t     ex1_xd;
	logic      ex1_xmex1;
	logic      ex1_xmex2;

	// EX1/EX2 register and the forwarded EX2 operand
	op_e       ex2_op;
	reg_addr_t ex2_ra;
	data_t     ex2_xd;
	logic      ex2_xmex1;
	data_t     ex2_fwd;

	fetch_stage fetch_i (
		.CLK        (CLK),
		.RSTB       (RSTB),
		.stall      (stall),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.id_instr   (id_instr)
	);

	decode_stage decode_i (
		.CLK       (CLK),
		.RSTB      (RSTB),
		.id_instr  (id_instr),
		.ex2_ra    (ex2_ra),
		.wb_write  (wb_write),
		.wb_ra     (wb_ra),
		.wb_rd     (wb_rd),
		.stall     (stall),
		.ex1_op    (ex1_op),
		.ex1_ra    (ex1_ra),
		.ex1_xd    (ex1_xd),
		.ex1_xmex1 (ex1_xmex1),
		.ex1_xmex2 (ex1_xmex2)
	);

	ex1_stage ex1_i (
		.CLK       (CLK),
		.RSTB      (RSTB),
		.ex1_op    (ex1_op),
		.ex1_ra    (ex1_ra),
		.ex1_xd    (ex1_xd),
		.ex1_xmex1 (ex1_xmex1),
		.ex1_xmex2 (ex1_xmex2),
		.ex2_fwd   (ex2_fwd),
		.wb_write  (wb_write),
		.wb_rd     (wb_rd),
		.ex2_op    (ex2_op),
		.ex2_ra    (ex2_ra),
		.ex2_xd    (ex2_xd),
		.ex2_xmex1 (ex2_xmex1)
	);

	ex2_stage ex2_i (
		.CLK       (CLK),
		.RSTB      (RSTB),
		.ex2_op    (ex2_op),
		.ex2_ra    (ex2_ra),
		.ex2_xd    (ex2_xd),
		.ex2_xmex1 (ex2_xmex1),
		.ex2_fwd   (ex2_fwd),
		.wb_write  (wb_write),
		.wb_ra     (wb_ra),
		.wb_rd     (wb_rd)
	);

endmodule

// ==== tests/pipe_cases.txt ====
# Header: case <name> <instruction count> <write-back count>, then one hex instruction per line
# Then one expected write-back per line in program order: <destination register> <value>, hex
case indep 4 4
80000010
40000020
20000030
10000040
1 0000
2 fffd
3 0004
4 0001

case forward 7 7
20000010
80000021
40000032
20000033
80000043
40000053
20000065
1 0004
2 0004
3 0001
3 0005
4 0005
5 0002
6 0006

case stall 7 7
20000010
40000021
10000032
10000043
10000044
40000054
20000055
1 0004
2 0001
3 0002
4 0003
4 0004
5 0001
5 0005

case bypass 5 5
20000010
80000020
80000030
40000041
10000051
1 0004
2 0000
3 0000
4 0001
5 0005

case nops 6 2
00000000
00000011
20000070
00000077
40000087
00000000
7 0004
8 0001

// ==== tests/pipe_tb.sv ====
// Testbench for the five-stage pipelined datapath
// Loads each program into instruction memory while the pipeline is held in
// reset, then follows the write-back stream and compares every register
// write in program order with the expected register and value. Directed
// programs and their results come from the case file, and random programs
// are checked against a sequential model of the instruction set
`timescale 1ns/1ps

module pipe_tb;

	import pipe_pkg::*;

	localparam int    CLK_HALF     = 20;
	localparam int    RESET_CYCLES = 16;
	localparam int    DRAIN_CYCLES = 4;
	localparam int    RAND_TESTS   = 20;
	localparam int    RAND_LEN     = 24;
	localparam string CASE_FILE    = "tests/pipe_cases.txt";

	logic      CLK;
	logic      RSTB;
	logic      imem_we;
	imem_addr_t imem_addr;
	instr_t    imem_wdata;
	logic      wb_write;
	reg_addr_t wb_ra;
	data_t     wb_rd;

	// Directed cases as read from the file and flattened over all cases
	string     case_name [$];
	int        case_len [$];
	int        case_nexp [$];
	instr_t    case_words [$];
	reg_addr_t case_ra [$];
	data_t     case_rd [$];

	// Program and expected write-back stream of the test that is running
	instr_t    prog [IMEM_DEPTH];
	int        prog_len;
	reg_addr_t exp_ra [$];
	data_t     exp_rd [$];
	int        exp_idx;
	string     test_name;

	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          tests_failed;
	int          cycle_count;
	int          cycle_limit;
	logic [31:0] lfsr;

	pipe_top dut_i (
		.CLK        (CLK),
		.RSTB       (RSTB),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.wb_write   (wb_write),
		.wb_ra      (wb_ra),
		.wb_rd      (wb_rd)
	);

	always
	begin
		#(CLK_HALF) CLK = ~CLK;
	end

	// --------------------------------------------------------------------------
	// Write-back monitor and run limit
	// --------------------------------------------------------------------------

	// Registered outputs are taken at the rising edge, before they update
	always @(posedge CLK)
	begin
		if (RSTB && wb_write)
		begin
			assert (exp_idx < exp_ra.size())
			else
			begin
				$display("test %s wrote r%0d at %0t ns after all expected write-backs",
					test_name, wb_ra, $time);
				test_errors++;
			end
			if (exp_idx < exp_ra.size())
			begin
				assert ((wb_ra == exp_ra[exp_idx]) && (wb_rd == exp_rd[exp_idx]))
				else
				begin
					$display("error at %0t ns: %s write %0d gave r%0d = %h, expected r%0d = %h",
						$time, test_name, exp_idx, wb_ra, wb_rd,
						exp_ra[exp_idx], exp_rd[exp_idx]);
					test_errors++;
				end
			end
			exp_idx++;
		end
	end

	// The limit covers every program even if each instruction stalled once
	always @(posedge CLK)
	begin
		cycle_count++;
		if ((cycle_limit > 0) && (cycle_count >= cycle_limit))
		begin
			$display("timeout after %0d cycles, test %s saw only %0d of %0d write-backs",
				cycle_count, test_name, exp_idx, exp_ra.size());
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// --------------------------------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------------------------------

	// Cycles one test may take for the load, the reset, two per instruction and the drain
	function automatic int test_cycles(input int len);
		return IMEM_DEPTH + RESET_CYCLES + 2 * len + 8;
	endfunction

	// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic read_cases();
		int          fd;
		int          n;
		int          words_left;
		int          writes_left;
		int          len;
		int          nexp;
		string       line;
		string       tok;
		string       name;
		logic [31:0] word;
		logic [31:0] ra;
		logic [31:0] rd;
		words_left  = 0;
		writes_left = 0;
		fd = $fopen(CASE_FILE, "r");
		if (fd == 0)
		begin
			$display("could not open case file %s, directed tests skipped", CASE_FILE);
			total_errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				n    = $fgets(line, fd);
				n    = $sscanf(line, "%s", tok);
				// Blank lines and lines starting with # carry no data
				if ((n == 1) && (tok.getc(0) != "#"))
				begin
					if (words_left > 0)
					begin
						n = $sscanf(line, "%h", word);
						case_words.push_back(instr_t'(word));
						words_left--;
					end
					else if (writes_left > 0)
					begin
						n = $sscanf(line, "%h %h", ra, rd);
						case_ra.push_back(reg_addr_t'(ra));
						case_rd.push_back(data_t'(rd));
						writes_left--;
					end
					else if ($sscanf(line, "case %s %d %d", name, len, nexp) == 3)
					begin
						case_name.push_back(name);
						case_len.push_back(len);
						case_nexp.push_back(nexp);
						words_left  = len;
						writes_left = nexp;
					end
					else
					begin
						$display("case file line not understood: %s", line);
						total_errors++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic clear_program();
		for (int a = 0; a < IMEM_DEPTH; a++)
		begin
			prog[a] = '0;
		end
	endtask

	// Opcode mix leans towards ADD4 and ADD1 to provoke the load-use stall,
	// and each program uses a window of four registers for dense hazards
	task automatic make_random_program(input int idx);
		logic [31:0] r;
		instr_t      word;
		op_e         op;
		clear_program();
		for (int i = 0; i < RAND_LEN; i++)
		begin
			draw_bits(3, r);
			case (r[2:0])
				3'd0:       op = OP_NOP;
				3'd1:       op = OP_MOV;
				3'd2, 3'd7: op = OP_SUB3;
				3'd3, 3'd5: op = OP_ADD4;
				default:    op = OP_ADD1;
			endcase
			word = '0;
			word[OP_LSB +: $bits(op_e)] = op;
			draw_bits(2, r);
			word[RA_LSB +: REG_AW] = {idx[1:0], r[1:0]};
			draw_bits(2, r);
			word[XA_LSB +: REG_AW] = {idx[1:0], r[1:0]};
			prog[i] = word;
		end
		prog_len = RAND_LEN;
	endtask

	// Sequential model in which every instruction sees all results before it
	task automatic predict_writes();
		data_t     model [NUM_REGS];
		data_t     val;
		op_e       op;
		reg_addr_t ra;
		reg_addr_t xa;
		for (int r = 0; r < NUM_REGS; r++)
		begin
			model[r] = '0;
		end
		exp_ra.delete();
		exp_rd.delete();
		for (int i = 0; i < prog_len; i++)
		begin
			op  = op_e'(prog[i][OP_LSB +: $bits(op_e)]);
			ra  = prog[i][RA_LSB +: REG_AW];
			xa  = prog[i][XA_LSB +: REG_AW];
			val = model[xa];
			case (op)
				OP_SUB3: val = val - 16'd3;
				OP_ADD4: val = val + 16'd4;
				OP_ADD1: val = val + 16'd1;
				default: val = model[xa];
			endcase
			if (op != OP_NOP)
			begin
				model[ra] = val;
				exp_ra.push_back(ra);
				exp_rd.push_back(val);
			end
		end
	endtask

	// Entered on a falling edge and writes all 64 words with zeros past the program
	task automatic load_program();
		RSTB        = 1'b0;
		exp_idx     = 0;
		test_errors = 0;
		for (int a = 0; a < IMEM_DEPTH; a++)
		begin
			imem_we    = 1'b1;
			imem_addr  = imem_addr_t'(a);
			imem_wdata = prog[a];
			@(negedge CLK);
		end
		imem_we = 1'b0;
		repeat (RESET_CYCLES) @(negedge CLK);
		RSTB = 1'b1;
	endtask

	task automatic run_test(input string name);
		test_name = name;
		load_program();
		while (exp_idx < exp_ra.size())
		begin
			@(negedge CLK);
		end
		// A few more cycles to catch a duplicated or stray write
		repeat (DRAIN_CYCLES) @(negedge CLK);
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0)
		begin
			$display("test %s passed, %0d write-backs", name, exp_ra.size());
		end
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, test_errors);
		end
	endtask

	// --------------------------------------------------------------------------
	// Test sequence
	// --------------------------------------------------------------------------

	initial
	begin
		int budget;
		int word_pos;
		int exp_pos;
		CLK          = 1'b0;
		RSTB         = 1'b0;
		imem_we      = 1'b0;
		imem_addr    = '0;
		imem_wdata   = '0;
		lfsr         = 32'h338bc179;
		exp_idx      = 0;
		test_errors  = 0;
		total_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		cycle_count  = 0;
		cycle_limit  = 0;
		test_name    = "setup";
		read_cases();
		budget = 0;
		foreach (case_len[i])
		begin
			budget += test_cycles(case_len[i]);
		end
		budget     += RAND_TESTS * test_cycles(RAND_LEN);
		cycle_limit = budget + 1;
		@(negedge CLK);
		word_pos = 0;
		exp_pos  = 0;
		for (int i = 0; i < case_name.size(); i++)
		begin
			clear_program();
			for (int w = 0; w < case_len[i]; w++)
			begin
				prog[w] = case_words[word_pos];
				word_pos++;
			end
			prog_len = case_len[i];
			exp_ra.delete();
			exp_rd.delete();
			for (int e = 0; e < case_nexp[i]; e++)
			begin
				exp_ra.push_back(case_ra[exp_pos]);
				exp_rd.push_back(case_rd[exp_pos]);
				exp_pos++;
			end
			run_test(case_name[i]);
		end
		for (int i = 0; i < RAND_TESTS; i++)
		begin
			make_random_program(i);
			predict_writes();
			run_test($sformatf("random_%0d", i));
		end
		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, total_errors);
		if ((tests_failed == 0) && (total_errors == 0))
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
